// ==== project.f ====
video_pkg.sv
dual_port_ram.sv
video_regs.sv
cpu_port.sv
line_fetcher.sv
pixel_mapper.sv
video_controller.sv
vram_model.sv
tb_video_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP ?= tb_video_controller
FILELIST ?= project.f

BUILD_DIR := obj_dir
LOG := sim.log
PASS_TEXT := all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_video_controller.sv ====
`timescale 1ns/1ps

module tb_video_controller;
	import video_pkg::*;

	localparam int TIMEOUT = 400;
	localparam int PITCH = 32;
	localparam int ROWS = 4;
	localparam vram_addr_t OFFSET = 32'h0000_0100;
	localparam vram_addr_t PALETTE_BASE = 32'h00E0_0000;
	localparam vram_addr_t CONTROL_BASE = 32'h00F0_0000;

	logic clock;
	logic rst_n;
	logic cpu_request;
	logic cpu_rw;
	vram_addr_t cpu_address;
	word_t cpu_wdata;
	word_t cpu_rdata;
	logic cpu_ready;
	logic hblank;
	logic vblank;
	screen_coord_t pos_x;
	screen_coord_t pos_y;
	word_t video_rdata;

	logic pa_request;
	logic pa_rw;
	vram_addr_t pa_address;
	word_t pa_wdata;
	word_t pa_rdata;
	logic pa_ready;
	logic pb_request;
	logic pb_rw;
	vram_addr_t pb_address;
	word_t pb_wdata;
	word_t pb_rdata;
	logic pb_ready;

	logic [15:0] lfsr_state = 16'd33;
	logic ready_seen = 1'b0;
	int frames = 0;

	video_controller video_controller_i (
		.i_clock(clock), .i_rst_n(rst_n),
		.i_cpu_request(cpu_request), .i_cpu_rw(cpu_rw), .i_cpu_address(cpu_address),
		.i_cpu_wdata(cpu_wdata), .o_cpu_rdata(cpu_rdata), .o_cpu_ready(cpu_ready),
		.i_video_hblank(hblank), .i_video_vblank(vblank),
		.i_video_pos_x(pos_x), .i_video_pos_y(pos_y), .o_video_rdata(video_rdata),
		.o_vram_pa_request(pa_request), .o_vram_pa_rw(pa_rw), .o_vram_pa_address(pa_address),
		.o_vram_pa_wdata(pa_wdata), .i_vram_pa_rdata(pa_rdata), .i_vram_pa_ready(pa_ready),
		.o_vram_pb_request(pb_request), .o_vram_pb_rw(pb_rw), .o_vram_pb_address(pb_address),
		.o_vram_pb_wdata(pb_wdata), .i_vram_pb_rdata(pb_rdata), .i_vram_pb_ready(pb_ready)
	);

	vram_model vram_i (
		.i_clock(clock), .i_rst_n(rst_n),
		.i_pa_request(pa_request), .i_pa_rw(pa_rw), .i_pa_address(pa_address),
		.i_pa_wdata(pa_wdata), .o_pa_rdata(pa_rdata), .o_pa_ready(pa_ready),
		.i_pb_request(pb_request), .i_pb_address(pb_address),
		.o_pb_rdata(pb_rdata), .o_pb_ready(pb_ready)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// ========================================
	// Reporting and reference model

	task automatic abort_test(input string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic report_mismatch(input string msg);
		abort_test($sformatf("mismatch at time %0t: %s", $time, msg));
	endtask

	task automatic expect_word(input word_t got, input word_t want, input string what);
		assert (got == want)
			else report_mismatch($sformatf("%s got %h expected %h", what, got, want));
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	function automatic word_t random_bits(input int count);
		word_t value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic rgb_t palette_color(input color_index_t index);
		return {index ^ 8'hA5, index * 8'd7, ~index};
	endfunction

	// Frame byte for each VRAM byte address
	function automatic color_index_t fill_byte(input vram_addr_t address);
		return (address[7:0] * 8'd37) ^ address[15:8] ^ address[23:16] ^ address[31:24];
	endfunction

	function automatic word_t expected_pixel(input int x, input int y, input logic [1:0] skip);
		int row;
		int col;
		vram_addr_t address;
		row = skip[1] ? y / 2 : y;
		col = skip[0] ? x / 2 : x;
		address = OFFSET + vram_addr_t'(row * PITCH + col);
		return {8'h00, palette_color(fill_byte(address))};
	endfunction

	function automatic vram_addr_t reg_addr(input logic [1:0] index);
		return CONTROL_BASE | {28'd0, index, 2'b00};
	endfunction

	// Ready pulse width and VRAM port fields on every cycle
	always @(negedge clock) begin
		if (rst_n) begin
			assert (!(cpu_ready && ready_seen))
				else report_mismatch("o_cpu_ready high for more than one cycle");
			if (pa_request) begin
				assert (pa_address[31:24] == 8'h00)
					else report_mismatch($sformatf("port A address %h keeps upper byte",
						pa_address));
			end
			if (pb_request) begin
				assert (!pb_rw && pb_wdata == '0)
					else report_mismatch($sformatf("port B rw %b wdata %h on a read",
						pb_rw, pb_wdata));
			end
		end
		ready_seen <= cpu_ready;
	end

	// ========================================
	// CPU bus and scan tasks

	task automatic cpu_access(input logic rw, input vram_addr_t address, input word_t wdata,
			output word_t rdata);
		int waited;
		waited = 0;
		@(posedge clock);
		cpu_request <= 1'b1;
		cpu_rw <= rw;
		cpu_address <= address;
		cpu_wdata <= wdata;
		@(negedge clock);
		while (!cpu_ready) begin
			if (waited == TIMEOUT) begin
				abort_test("CPU access got no ready before the timeout");
			end
			waited++;
			@(negedge clock);
		end
		rdata = cpu_rdata;
		@(posedge clock);
		cpu_request <= 1'b0;
	endtask

	task automatic cpu_write(input vram_addr_t address, input word_t wdata);
		word_t unused;
		cpu_access(1'b1, address, wdata, unused);
	endtask

	task automatic wait_fetch_done();
		int waited;
		waited = 0;
		@(negedge clock);
		while (pb_request) begin
			if (waited == TIMEOUT) begin
				abort_test("line fetch did not finish before the timeout");
			end
			waited++;
			@(negedge clock);
		end
		// Last word still on its way into the line buffer
		repeat (2) @(posedge clock);
	endtask

	task automatic scan_frame(input logic [1:0] skip);
		@(posedge clock);
		hblank <= 1'b1;
		vblank <= 1'b1;
		repeat (4) @(posedge clock);
		vblank <= 1'b0;
		frames++;
		wait_fetch_done();
		for (int y = 0; y < ROWS; y++) begin
			@(posedge clock);
			hblank <= 1'b0;
			pos_y <= screen_coord_t'(y);
			// Color of x shows up three cycles later
			for (int x = 0; x < PITCH + 3; x++) begin
				if (x < PITCH) begin
					pos_x <= screen_coord_t'(x);
				end
				@(negedge clock);
				if (x >= 3) begin
					expect_word(video_rdata, expected_pixel(x - 3, y, skip),
						$sformatf("pixel x %0d y %0d skip %0d", x - 3, y, skip));
				end
				@(posedge clock);
			end
			hblank <= 1'b1;
			repeat (4) @(posedge clock);
			wait_fetch_done();
		end
	endtask

	// ========================================
	// Test sequence

	initial begin
		word_t value;
		vram_addr_t address;
		vram_addr_t addresses [8];
		word_t words [8];
		rst_n = 1'b0;
		cpu_request = 1'b0;
		cpu_rw = 1'b0;
		cpu_address = '0;
		cpu_wdata = '0;
		hblank = 1'b1;
		vblank = 1'b0;
		pos_x = '0;
		pos_y = '0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;

		@(negedge clock);
		assert (!cpu_ready && !pa_request && !pb_request)
			else report_mismatch("outputs not idle after reset");
		cpu_access(1'b0, reg_addr(REG_FRAME_COUNT), '0, value);
		expect_word(value, 32'd0, "frame count after reset");

		cpu_write(reg_addr(REG_READ_OFFSET), OFFSET);
		cpu_write(reg_addr(REG_PITCH), 32'(PITCH));
		cpu_write(reg_addr(REG_SKIP), 32'd3);
		cpu_access(1'b0, reg_addr(REG_READ_OFFSET), '0, value);
		expect_word(value, OFFSET, "read offset");
		cpu_access(1'b0, reg_addr(REG_PITCH), '0, value);
		expect_word(value, 32'(PITCH), "pitch");
		cpu_access(1'b0, reg_addr(REG_SKIP), '0, value);
		expect_word(value, 32'd3, "skip");

		// Random VRAM words with varying upper byte and region bits
		for (int i = 0; i < 8; i++) begin
			addresses[i] = (random_bits(8) << 24) | (random_bits(3) << 20) | 32'h800
				| (random_bits(9) << 2);
			words[i] = random_bits(32);
			cpu_write(addresses[i], words[i]);
			expect_word(vram_i.mem[addresses[i][11:2]], words[i], "VRAM model after write");
		end
		for (int i = 0; i < 8; i++) begin
			cpu_access(1'b0, addresses[i], '0, value);
			expect_word(value, vram_i.mem[addresses[i][11:2]], "VRAM read back");
		end

		for (int i = 0; i < PALETTE_SIZE; i++) begin
			cpu_write(PALETTE_BASE | vram_addr_t'(i << 2), {8'h00, palette_color(8'(i))});
		end
		for (int w = 0; w < (ROWS + 1) * PITCH / 4; w++) begin
			address = OFFSET + vram_addr_t'(w * 4);
			cpu_write(address, {fill_byte(address + 3), fill_byte(address + 2),
				fill_byte(address + 1), fill_byte(address)});
		end

		cpu_write(reg_addr(REG_SKIP), 32'd0);
		scan_frame(2'b00);
		cpu_write(reg_addr(REG_SKIP), 32'd1);
		scan_frame(2'b01);
		cpu_write(reg_addr(REG_SKIP), 32'd2);
		scan_frame(2'b10);

		cpu_access(1'b0, reg_addr(REG_FRAME_COUNT), '0, value);
		expect_word(value, 32'(frames), "frame count");

		$display("all tests passed");
		$finish;
	end

endmodule

// ==== vram_model.sv ====
`timescale 1ns/1ps

module vram_model #(
	parameter int WORDS = 1024
) (
	input logic i_clock,
	input logic i_rst_n,

	input logic i_pa_request,
	input logic i_pa_rw,
	input video_pkg::vram_addr_t i_pa_address,
	input video_pkg::word_t i_pa_wdata,
	output video_pkg::word_t o_pa_rdata,
	output logic o_pa_ready,

	input logic i_pb_request,
	input video_pkg::vram_addr_t i_pb_address,
	output video_pkg::word_t o_pb_rdata,
	output logic o_pb_ready
);
	import video_pkg::*;

	localparam int AW = $clog2(WORDS);

	word_t mem [WORDS];
	logic [15:0] lfsr;

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	// Read data is valid whenever the request is up
	assign o_pa_rdata = mem[i_pa_address[AW+1:2]];
	assign o_pb_rdata = mem[i_pb_address[AW+1:2]];

	// ========================================
	// Random ready and port A writes

	always @(posedge i_clock or negedge i_rst_n) begin
		logic [15:0] state;
		logic bit_a;
		logic bit_b0;
		logic bit_b1;
		if (!i_rst_n) begin
			lfsr <= 16'd33;
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
		end else begin
			state = lfsr_step(lfsr);
			bit_a = state[0];
			state = lfsr_step(state);
			bit_b0 = state[0];
			state = lfsr_step(state);
			bit_b1 = state[0];
			lfsr <= state;
			// Port A ready about half the time, port B three quarters
			o_pa_ready <= bit_a;
			o_pb_ready <= bit_b0 | bit_b1;
			if (i_pa_request && o_pa_ready && i_pa_rw) begin
				mem[i_pa_address[AW+1:2]] <= i_pa_wdata;
			end
		end
	end

endmodule

// ==== video_controller.sv ====
`timescale 1ns/1ps

module video_controller (
	input logic i_clock,
	input logic i_rst_n,

	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::vram_addr_t i_cpu_address,
	input video_pkg::word_t i_cpu_wdata,
	output video_pkg::word_t o_cpu_rdata,
	output logic o_cpu_ready,

	input logic i_video_hblank,
	input logic i_video_vblank,
	input video_pkg::screen_coord_t i_video_pos_x,
	input video_pkg::screen_coord_t i_video_pos_y,
	output video_pkg::word_t o_video_rdata,

	output logic o_vram_pa_request,
	output logic o_vram_pa_rw,
	output video_pkg::vram_addr_t o_vram_pa_address,
	output video_pkg::word_t o_vram_pa_wdata,
	input video_pkg::word_t i_vram_pa_rdata,
	input logic i_vram_pa_ready,

	output logic o_vram_pb_request,
	output logic o_vram_pb_rw,
	output video_pkg::vram_addr_t o_vram_pb_address,
	output video_pkg::word_t o_vram_pb_wdata,
	input video_pkg::word_t i_vram_pb_rdata,
	input logic i_vram_pb_ready
);
	import video_pkg::*;

	reg_access_t reg_access;
	word_t reg_rdata;
	video_config_t video_config;
	palette_write_t palette_write;
	line_write_t line_write;
	line_addr_t line_raddr;
	word_t line_rdata;
	color_index_t palette_raddr;
	rgb_t palette_rdata;

	// Port B only reads
	assign o_vram_pb_rw = 1'b0;
	assign o_vram_pb_wdata = '0;

	// ========================================
	// CPU side

	cpu_port cpu_port_i (
		.i_clock, .i_rst_n,
		.i_cpu_request, .i_cpu_rw, .i_cpu_address, .i_cpu_wdata,
		.o_cpu_rdata, .o_cpu_ready,
		.i_reg_rdata(reg_rdata), .o_reg_access(reg_access),
		.o_palette_write(palette_write),
		.o_vram_pa_request, .o_vram_pa_rw, .o_vram_pa_address,
		.o_vram_pa_wdata, .i_vram_pa_rdata, .i_vram_pa_ready
	);

	video_regs video_regs_i (
		.i_clock, .i_rst_n, .i_access(reg_access), .i_vblank(i_video_vblank),
		.o_rdata(reg_rdata), .o_config(video_config)
	);

	dual_port_ram #(.WIDTH(24), .DEPTH(PALETTE_SIZE)) palette_ram_i (
		.i_clock, .i_write(palette_write.valid), .i_waddr(palette_write.addr),
		.i_raddr(palette_raddr), .i_wdata(palette_write.data), .o_rdata(palette_rdata)
	);

	// ========================================
	// Scan-out side

	line_fetcher line_fetcher_i (
		.i_clock, .i_rst_n, .i_video_hblank, .i_video_vblank,
		.i_config(video_config), .o_line_write(line_write),
		.o_vram_pb_request, .o_vram_pb_address, .i_vram_pb_rdata, .i_vram_pb_ready
	);

	dual_port_ram #(.WIDTH(32), .DEPTH(LINE_WORDS)) line_ram_i (
		.i_clock, .i_write(line_write.valid),
		.i_waddr(line_write.addr[$clog2(LINE_WORDS)-1:0]),
		.i_raddr(line_raddr[$clog2(LINE_WORDS)-1:0]),
		.i_wdata(line_write.data), .o_rdata(line_rdata)
	);

	pixel_mapper pixel_mapper_i (
		.i_clock, .i_rst_n, .i_pos_x(i_video_pos_x), .i_skip_x(video_config.skip[0]),
		.i_line_rdata(line_rdata), .i_palette_rdata(palette_rdata),
		.o_line_addr(line_raddr), .o_palette_addr(palette_raddr), .o_video_rdata
	);

endmodule

// ==== pixel_mapper.sv ====
`timescale 1ns/1ps

module pixel_mapper (
	input logic i_clock,
	input logic i_rst_n,
	input video_pkg::screen_coord_t i_pos_x,
	input logic i_skip_x,
	input video_pkg::word_t i_line_rdata,
	input video_pkg::rgb_t i_palette_rdata,
	output video_pkg::line_addr_t o_line_addr,
	output video_pkg::color_index_t o_palette_addr,
	output video_pkg::word_t o_video_rdata
);
	import video_pkg::*;

	logic [1:0] lane;
	logic [1:0] lane_q;

	// Four pixels per word, each pixel twice when doubling
	always_comb begin
		if (i_skip_x) begin
			o_line_addr = {1'b0, i_pos_x[10:3]};
			lane = i_pos_x[2:1];
		end else begin
			o_line_addr = i_pos_x[10:2];
			lane = i_pos_x[1:0];
		end
	end

	// Lane follows the line buffer read
	always_ff @(posedge i_clock) begin
		lane_q <= lane;
	end

	always_comb begin
		unique case (lane_q)
			2'd0: o_palette_addr = i_line_rdata[7:0];
			2'd1: o_palette_addr = i_line_rdata[15:8];
			2'd2: o_palette_addr = i_line_rdata[23:16];
			default: o_palette_addr = i_line_rdata[31:24];
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_video_rdata <= '0;
		end else begin
			o_video_rdata <= {8'h00, i_palette_rdata};
		end
	end

endmodule

// ==== line_fetcher.sv ====
`timescale 1ns/1ps

module line_fetcher (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_video_hblank,
	input logic i_video_vblank,
	input video_pkg::video_config_t i_config,
	output video_pkg::line_write_t o_line_write,

	output logic o_vram_pb_request,
	output video_pkg::vram_addr_t o_vram_pb_address,
	input video_pkg::word_t i_vram_pb_rdata,
	input logic i_vram_pb_ready
);
	import video_pkg::*;

	logic [1:0] hblank_sync;
	logic [1:0] vblank_sync;
	logic frame_start;
	logic line_start;
	logic line_fetch;
	logic beat;
	logic last_beat;
	logic has_words;

	vram_addr_t row_addr;
	vram_addr_t next_row_addr;
	line_addr_t column;
	line_addr_t line_words;
	logic line_odd;

	logic write_valid;
	line_addr_t write_addr;
	word_t write_data;

	// ========================================
	// Edge detect and fetch conditions

	assign frame_start = (vblank_sync == 2'b01);
	assign line_start = (hblank_sync == 2'b01) && !vblank_sync[0];
	// Every second line repeats when skip bit 1 is set
	assign line_fetch = line_start && (!i_config.skip[1] || line_odd);

	assign line_words = line_addr_t'(i_config.pitch >> 2);
	assign has_words = (line_words != '0);
	assign next_row_addr = row_addr + i_config.pitch;

	assign beat = o_vram_pb_request && i_vram_pb_ready;
	assign last_beat = beat && (column == line_words - 9'd1);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			hblank_sync <= '0;
			vblank_sync <= '0;
			row_addr <= '0;
			column <= '0;
			line_odd <= 1'b0;
			o_vram_pb_request <= 1'b0;
			write_valid <= 1'b0;
		end else begin
			hblank_sync <= {hblank_sync[0], i_video_hblank};
			vblank_sync <= {vblank_sync[0], i_video_vblank};
			write_valid <= beat;
			if (frame_start) begin
				row_addr <= i_config.read_offset;
				column <= '0;
				line_odd <= 1'b0;
				o_vram_pb_request <= has_words;
			end else if (line_start) begin
				line_odd <= !line_odd;
				if (line_fetch) begin
					row_addr <= next_row_addr;
					column <= '0;
					o_vram_pb_request <= has_words;
				end
			end else if (beat) begin
				column <= column + 9'd1;
				if (last_beat) begin
					o_vram_pb_request <= 1'b0;
				end
			end
		end
	end

	// ========================================
	// Port B address and line buffer data

	always_ff @(posedge i_clock) begin
		if (frame_start) begin
			o_vram_pb_address <= i_config.read_offset;
		end else if (line_fetch) begin
			o_vram_pb_address <= next_row_addr;
		end else if (beat) begin
			o_vram_pb_address <= o_vram_pb_address + 32'd4;
		end
		write_addr <= column;
		write_data <= i_vram_pb_rdata;
	end

	assign o_line_write = '{valid: write_valid, addr: write_addr, data: write_data};

endmodule

// ==== cpu_port.sv ====
`timescale 1ns/1ps

module cpu_port (
	input logic i_clock,
	input logic i_rst_n,

	input logic i_cpu_request,
	input logic i_cpu_rw,
	input video_pkg::vram_addr_t i_cpu_address,
	input video_pkg::word_t i_cpu_wdata,
	output video_pkg::word_t o_cpu_rdata,
	output logic o_cpu_ready,

	input video_pkg::word_t i_reg_rdata,
	output video_pkg::reg_access_t o_reg_access,
	output video_pkg::palette_write_t o_palette_write,

	output logic o_vram_pa_request,
	output logic o_vram_pa_rw,
	output video_pkg::vram_addr_t o_vram_pa_address,
	output video_pkg::word_t o_vram_pa_wdata,
	input video_pkg::word_t i_vram_pa_rdata,
	input logic i_vram_pa_ready
);
	import video_pkg::*;

	cpu_state_t state;
	logic [3:0] region;
	logic accept;
	logic reg_write;
	logic [1:0] reg_index;
	word_t reg_wdata;
	logic palette_valid;
	color_index_t palette_addr;
	rgb_t palette_data;

	assign region = i_cpu_address[23:20];
	assign accept = (state == IDLE) && i_cpu_request;

	// ========================================
	// Access FSM

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			o_cpu_ready <= 1'b0;
			o_vram_pa_request <= 1'b0;
			reg_write <= 1'b0;
			palette_valid <= 1'b0;
		end else begin
			o_cpu_ready <= 1'b0;
			reg_write <= 1'b0;
			palette_valid <= 1'b0;
			unique case (state)
				IDLE: begin
					if (i_cpu_request) begin
						if (region == REGION_PALETTE) begin
							palette_valid <= i_cpu_rw;
							state <= PALETTE;
						end else if (region == REGION_CONTROL) begin
							reg_write <= i_cpu_rw;
							state <= CONTROL;
						end else begin
							o_vram_pa_request <= 1'b1;
							state <= VRAM_WAIT;
						end
					end
				end
				VRAM_WAIT: begin
					if (i_vram_pa_ready) begin
						o_vram_pa_request <= 1'b0;
						o_cpu_ready <= 1'b1;
						state <= RELEASE;
					end
				end
				PALETTE, CONTROL: begin
					o_cpu_ready <= 1'b1;
					state <= RELEASE;
				end
				RELEASE: begin
					// Hold off until the CPU drops its request
					if (!i_cpu_request) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Access payload
	always_ff @(posedge i_clock) begin
		if (accept) begin
			reg_index <= i_cpu_address[3:2];
			reg_wdata <= i_cpu_wdata;
			palette_addr <= i_cpu_address[9:2];
			palette_data <= i_cpu_wdata[23:0];
			o_vram_pa_rw <= i_cpu_rw;
			o_vram_pa_address <= {8'h00, i_cpu_address[23:0]};
			o_vram_pa_wdata <= i_cpu_wdata;
		end
		if (state == CONTROL) begin
			o_cpu_rdata <= i_reg_rdata;
		end else if (state == PALETTE) begin
			o_cpu_rdata <= '0;
		end else if (state == VRAM_WAIT && i_vram_pa_ready) begin
			o_cpu_rdata <= i_vram_pa_rdata;
		end
	end

	assign o_reg_access = '{write: reg_write, index: reg_index, wdata: reg_wdata};
	assign o_palette_write = '{valid: palette_valid, addr: palette_addr, data: palette_data};

endmodule

// ==== video_regs.sv ====
`timescale 1ns/1ps

module video_regs (
	input logic i_clock,
	input logic i_rst_n,
	input video_pkg::reg_access_t i_access,
	input logic i_vblank,
	output video_pkg::word_t o_rdata,
	output video_pkg::video_config_t o_config
);
	import video_pkg::*;

	vram_addr_t read_offset;
	word_t pitch;
	logic [1:0] skip;
	word_t frame_count;
	logic [1:0] vblank_sync;
	logic vblank_rise;

	// Older sample in bit 1
	assign vblank_rise = (vblank_sync == 2'b01);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			read_offset <= '0;
			pitch <= '0;
			skip <= '0;
			frame_count <= '0;
			vblank_sync <= '0;
		end else begin
			vblank_sync <= {vblank_sync[0], i_vblank};
			if (vblank_rise) begin
				frame_count <= frame_count + 32'd1;
			end
			// Frame counter is read-only
			if (i_access.write) begin
				unique case (i_access.index)
					REG_READ_OFFSET: read_offset <= i_access.wdata;
					REG_PITCH: pitch <= i_access.wdata;
					REG_SKIP: skip <= i_access.wdata[1:0];
					default: ;
				endcase
			end
		end
	end

	// CPU read-back
	always_comb begin
		unique case (i_access.index)
			REG_READ_OFFSET: o_rdata = read_offset;
			REG_PITCH: o_rdata = pitch;
			REG_SKIP: o_rdata = {30'd0, skip};
			REG_FRAME_COUNT: o_rdata = frame_count;
			default: o_rdata = '0;
		endcase
	end

	assign o_config = '{
		read_offset: read_offset,
		pitch: pitch,
		skip: skip
	};

endmodule

// ==== dual_port_ram.sv ====
`timescale 1ns/1ps

module dual_port_ram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 256
) (
	input logic i_clock,
	input logic i_write,
	input logic [$clog2(DEPTH)-1:0] i_waddr,
	input logic [$clog2(DEPTH)-1:0] i_raddr,
	input logic [WIDTH-1:0] i_wdata,
	output logic [WIDTH-1:0] o_rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Write port
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// Registered read, one cycle latency
	always_ff @(posedge i_clock) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

// ==== video_pkg.sv ====
package video_pkg;

	// ========================================
	// Sizes and address map

	localparam int MAX_PITCH = 640;
	localparam int LINE_WORDS = MAX_PITCH / 4;
	localparam int PALETTE_SIZE = 256;

	// Region select is address bits 23:20
	localparam logic [3:0] REGION_PALETTE = 4'hE;
	localparam logic [3:0] REGION_CONTROL = 4'hF;

	// Register index from address bits 3:2
	localparam logic [1:0] REG_READ_OFFSET = 2'd0;
	localparam logic [1:0] REG_PITCH = 2'd1;
	localparam logic [1:0] REG_SKIP = 2'd2;
	localparam logic [1:0] REG_FRAME_COUNT = 2'd3;

	// ========================================
	// Types

	typedef logic [31:0] word_t;
	typedef logic [31:0] vram_addr_t;
	typedef logic [23:0] rgb_t;
	typedef logic [7:0] color_index_t;
	typedef logic [10:0] screen_coord_t;
	typedef logic [8:0] line_addr_t;

	typedef struct packed {
		vram_addr_t read_offset;
		word_t pitch;
		logic [1:0] skip;
	} video_config_t;

	typedef struct packed {
		logic valid;
		line_addr_t addr;
		word_t data;
	} line_write_t;

	typedef struct packed {
		logic valid;
		color_index_t addr;
		rgb_t data;
	} palette_write_t;

	typedef struct packed {
		logic write;
		logic [1:0] index;
		word_t wdata;
	} reg_access_t;

	typedef enum logic [2:0] {
		IDLE,
		VRAM_WAIT,
		PALETTE,
		CONTROL,
		RELEASE
	} cpu_state_t;

endpackage
